// ==== project.f ====
source/line_cache_pkg.sv
source/sync_fifo.sv
source/line_buffer.sv
source/avl_master.sv
source/line_cache_ctrl.sv
source/ddr3_line_cache.sv
tests/tb_clock.sv
tests/avl_mem_model.sv
tests/ddr3_line_cache_tb.sv

// ==== source/avl_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module avl_master (
  input  logic                                  clk,
  input  logic                                  rst,
  input  line_cache_pkg::avl_cmd_t              i_cmd,
  input  logic                                  i_cmd_empty,
  input  logic                                  i_avl_ready,
  input  logic                                  i_avl_rdata_valid,
  input  logic [line_cache_pkg::LINE_W-1:0]     i_avl_rdata,
  output logic                                  o_cmd_pop,
  output logic                                  o_avl_read,
  output logic                                  o_avl_write,
  output logic [line_cache_pkg::AVL_ADDR_W-1:0] o_avl_addr,
  output logic [line_cache_pkg::LINE_W-1:0]     o_avl_wdata,
  output logic                                  o_fill_valid,
  output logic [line_cache_pkg::LINE_W-1:0]     o_fill_data
);

  import line_cache_pkg::*;

  logic st_idle;
  logic st_request;
  logic st_receive;
  logic cmd_write_q;

  always_ff @(posedge clk)
  begin
    st_idle    <= 1'b0;
    st_request <= 1'b0;
    st_receive <= 1'b0;

    o_cmd_pop    <= 1'b0;
    o_fill_valid <= 1'b0;

    case (1'b1)
      st_idle:
      begin
        if (!i_cmd_empty)
        begin
          // take the head entry, address and data stay put until done
          o_cmd_pop   <= 1'b1;
          cmd_write_q <= i_cmd.write;
          o_avl_addr  <= {i_cmd.line_addr, {(AVL_ADDR_W-LINE_ADDR_W){1'b0}}};
          o_avl_wdata <= i_cmd.data;
          st_request  <= 1'b1;
        end
        else
        begin
          st_idle <= 1'b1;
        end
      end
      st_request:
      begin
        if (!o_avl_read && !o_avl_write)
        begin
          // first request cycle follows the pop
          o_avl_read  <= !cmd_write_q;
          o_avl_write <= cmd_write_q;
          st_request  <= 1'b1;
        end
        else if (i_avl_ready)
        begin
          o_avl_read  <= 1'b0;
          o_avl_write <= 1'b0;
          if (o_avl_read)
          begin
            st_receive <= 1'b1;
          end
          else
          begin
            st_idle <= 1'b1;
          end
        end
        else
        begin
          st_request <= 1'b1;
        end
      end
      st_receive:
      begin
        if (i_avl_rdata_valid)
        begin
          o_fill_valid <= 1'b1;
          o_fill_data  <= i_avl_rdata;
          st_idle      <= 1'b1;
        end
        else
        begin
          st_receive <= 1'b1;
        end
      end
      default:
      begin
        st_idle <= 1'b1;
      end
    endcase

    if (rst)
    begin
      st_idle      <= 1'b1;
      st_request   <= 1'b0;
      st_receive   <= 1'b0;
      o_cmd_pop    <= 1'b0;
      o_avl_read   <= 1'b0;
      o_avl_write  <= 1'b0;
      o_fill_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/ddr3_line_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_line_cache (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  i_membus_req,
  input  logic                                  i_membus_write,
  input  logic [31:0]                           i_membus_addr,
  input  logic [31:0]                           i_membus_wdata,
  input  logic [3:0]                            i_membus_wr_mask,
  input  logic                                  i_avl_ready,
  input  logic                                  i_avl_rdata_valid,
  input  logic [line_cache_pkg::LINE_W-1:0]     i_avl_rdata,
  output logic                                  o_membus_ack,
  output logic [31:0]                           o_membus_rdata,
  output logic                                  o_avl_read,
  output logic                                  o_avl_write,
  output logic [line_cache_pkg::AVL_ADDR_W-1:0] o_avl_addr,
  output logic [line_cache_pkg::LINE_W-1:0]     o_avl_wdata
);

  import line_cache_pkg::*;

  membus_req_t       req_data;
  avl_cmd_t          push_cmd;
  avl_cmd_t          head_cmd;
  logic              push;
  logic              fifo_full;
  logic              fifo_empty;
  logic              cmd_pop;
  logic              fill_valid;
  logic [LINE_W-1:0] fill_data;
  logic              access;
  logic [LINE_W-1:0] line;

  // bus request fields, held by the requester until the ack
  assign req_data.write     = i_membus_write;
  assign req_data.addr.flat = i_membus_addr;
  assign req_data.wdata     = i_membus_wdata;
  assign req_data.wr_mask   = i_membus_wr_mask;

  line_cache_ctrl i_ctrl (
    .clk          ( clk ),
    .rst          ( rst ),
    .i_req        ( i_membus_req ),
    .i_req_data   ( req_data ),
    .i_fifo_full  ( fifo_full ),
    .i_fill_valid ( fill_valid ),
    .i_line       ( line ),
    .o_push       ( push ),
    .o_cmd        ( push_cmd ),
    .o_access     ( access ),
    .o_ack        ( o_membus_ack )
  );

  line_buffer i_line_buffer (
    .clk         ( clk ),
    .rst         ( rst ),
    .i_fill      ( fill_valid ),
    .i_fill_data ( fill_data ),
    .i_access    ( access ),
    .i_req_data  ( req_data ),
    .o_line      ( line ),
    .o_rdata     ( o_membus_rdata )
  );

  sync_fifo #(
    .DEPTH ( CMD_FIFO_DEPTH )
  ) i_cmd_fifo (
    .clk     ( clk ),
    .rst     ( rst ),
    .i_push  ( push ),
    .i_data  ( push_cmd ),
    .i_pop   ( cmd_pop ),
    .o_data  ( head_cmd ),
    .o_empty ( fifo_empty ),
    .o_full  ( fifo_full )
  );

  avl_master i_avl_master (
    .clk               ( clk ),
    .rst               ( rst ),
    .i_cmd             ( head_cmd ),
    .i_cmd_empty       ( fifo_empty ),
    .i_avl_ready       ( i_avl_ready ),
    .i_avl_rdata_valid ( i_avl_rdata_valid ),
    .i_avl_rdata       ( i_avl_rdata ),
    .o_cmd_pop         ( cmd_pop ),
    .o_avl_read        ( o_avl_read ),
    .o_avl_write       ( o_avl_write ),
    .o_avl_addr        ( o_avl_addr ),
    .o_avl_wdata       ( o_avl_wdata ),
    .o_fill_valid      ( fill_valid ),
    .o_fill_data       ( fill_data )
  );

endmodule

`default_nettype wire

// ==== source/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_fill,
  input  logic [line_cache_pkg::LINE_W-1:0] i_fill_data,
  input  logic                              i_access,
  input  line_cache_pkg::membus_req_t       i_req_data,
  output logic [line_cache_pkg::LINE_W-1:0] o_line,
  output logic [31:0]                       o_rdata
);

  import line_cache_pkg::*;

  logic [WORD_SEL_W-1:0] word_sel;

  assign word_sel = i_req_data.addr.f.word_sel;

  // line storage, a fill replaces the whole line
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_line <= '0;
    end
    else if (i_fill)
    begin
      o_line <= i_fill_data;
    end
    else if (i_access && i_req_data.write)
    begin
      // merge only the enabled byte lanes of the selected word
      for (int b = 0; b < 4; b++)
      begin
        if (i_req_data.wr_mask[b])
        begin
          o_line[word_sel*32 + b*8 +: 8] <= i_req_data.wdata[b*8 +: 8];
        end
      end
    end
  end

  // read data register
  always_ff @(posedge clk)
  begin
    if (i_access)
    begin
      if (i_req_data.write)
      begin
        // writes echo the bus data back
        o_rdata <= i_req_data.wdata;
      end
      else
      begin
        o_rdata <= o_line[word_sel*32 +: 32];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/line_cache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_cache_ctrl (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              i_req,
  input  line_cache_pkg::membus_req_t       i_req_data,
  input  logic                              i_fifo_full,
  input  logic                              i_fill_valid,
  input  logic [line_cache_pkg::LINE_W-1:0] i_line,
  output logic                              o_push,
  output line_cache_pkg::avl_cmd_t          o_cmd,
  output logic                              o_access,
  output logic                              o_ack
);

  import line_cache_pkg::*;

  // one flag per state
  logic st_idle;
  logic st_wb_push;
  logic st_fill_push;
  logic st_fill_wait;
  logic st_update;
  logic st_ack;

  logic [LINE_ADDR_W-1:0] tag_q;
  logic                   valid_q;
  logic                   dirty_q;
  logic                   hit;

  assign hit = valid_q && (tag_q == i_req_data.addr.f.line_addr);

  always_ff @(posedge clk)
  begin
    st_idle      <= 1'b0;
    st_wb_push   <= 1'b0;
    st_fill_push <= 1'b0;
    st_fill_wait <= 1'b0;
    st_update    <= 1'b0;
    st_ack       <= 1'b0;

    o_push   <= 1'b0;
    o_access <= 1'b0;
    o_ack    <= 1'b0;

    case (1'b1)
      st_idle:
      begin
        if (!i_req)
        begin
          st_idle <= 1'b1;
        end
        else if (hit)
        begin
          st_update <= 1'b1;
        end
        else if (valid_q && dirty_q)
        begin
          st_wb_push <= 1'b1;
        end
        else
        begin
          st_fill_push <= 1'b1;
        end
      end
      st_wb_push:
      begin
        if (i_fifo_full)
        begin
          st_wb_push <= 1'b1;
        end
        else
        begin
          // old line goes out before the fill is queued
          o_push          <= 1'b1;
          o_cmd.write     <= 1'b1;
          o_cmd.line_addr <= tag_q;
          o_cmd.data      <= i_line;
          st_fill_push    <= 1'b1;
        end
      end
      st_fill_push:
      begin
        if (i_fifo_full)
        begin
          st_fill_push <= 1'b1;
        end
        else
        begin
          o_push          <= 1'b1;
          o_cmd.write     <= 1'b0;
          o_cmd.line_addr <= i_req_data.addr.f.line_addr;
          o_cmd.data      <= '0;
          tag_q           <= i_req_data.addr.f.line_addr;
          valid_q         <= 1'b0;
          dirty_q         <= 1'b0;
          st_fill_wait    <= 1'b1;
        end
      end
      st_fill_wait:
      begin
        if (i_fill_valid)
        begin
          // fresh line is clean, a pending write dirties it right away
          valid_q  <= 1'b1;
          dirty_q  <= i_req_data.write;
          o_access <= 1'b1;
          st_ack   <= 1'b1;
        end
        else
        begin
          st_fill_wait <= 1'b1;
        end
      end
      st_update:
      begin
        o_access <= 1'b1;
        if (i_req_data.write)
        begin
          dirty_q <= 1'b1;
        end
        st_ack <= 1'b1;
      end
      st_ack:
      begin
        o_ack   <= 1'b1;
        st_idle <= 1'b1;
      end
      default:
      begin
        st_idle <= 1'b1;
      end
    endcase

    if (rst)
    begin
      st_idle      <= 1'b1;
      st_wb_push   <= 1'b0;
      st_fill_push <= 1'b0;
      st_fill_wait <= 1'b0;
      st_update    <= 1'b0;
      st_ack       <= 1'b0;
      valid_q      <= 1'b0;
      dirty_q      <= 1'b0;
      o_push       <= 1'b0;
      o_access     <= 1'b0;
      o_ack        <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== source/line_cache_pkg.sv ====
`default_nettype none

package line_cache_pkg;

  localparam int LINE_ADDR_W    = 22;
  localparam int WORD_SEL_W     = 2;
  localparam int LINE_W         = 128;
  localparam int AVL_ADDR_W     = 26;
  localparam int CMD_FIFO_DEPTH = 4;

  // field view of a bus byte address
  typedef struct packed {
    logic [31-LINE_ADDR_W-WORD_SEL_W-2:0] unused;
    logic [LINE_ADDR_W-1:0]               line_addr;
    logic [WORD_SEL_W-1:0]                word_sel;
    logic [1:0]                           byte_off;
  } mem_addr_fields_t;

  // same 32 bits, flat or split into fields
  typedef union packed {
    logic [31:0]      flat;
    mem_addr_fields_t f;
  } mem_addr_u;

  // one request from the memory bus
  typedef struct packed {
    logic        write;
    mem_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  wr_mask;
  } membus_req_t;

  // one queued Avalon command, data only meaningful for writes
  typedef struct packed {
    logic                   write;
    logic [LINE_ADDR_W-1:0] line_addr;
    logic [LINE_W-1:0]      data;
  } avl_cmd_t;

endpackage

`default_nettype wire

// ==== source/sync_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DEPTH = line_cache_pkg::CMD_FIFO_DEPTH
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     i_push,
  input  line_cache_pkg::avl_cmd_t i_data,
  input  logic                     i_pop,
  output line_cache_pkg::avl_cmd_t o_data,
  output logic                     o_empty,
  output logic                     o_full
);

  import line_cache_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  avl_cmd_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             do_push;
  logic             do_pop;

  // pushes into a full queue and pops from an empty one are ignored
  assign do_push = i_push && !o_full;
  assign do_pop  = i_pop && !o_empty;

  assign o_data  = mem[rd_ptr];
  assign o_empty = (count == '0);
  assign o_full  = (count == DEPTH[PTR_W:0]);

  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= i_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      // pointers wrap on their own, depth is a power of two
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (do_push && !do_pop)
      begin
        count <= count + 1'b1;
      end
      else if (do_pop && !do_push)
      begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/avl_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module avl_mem_model (
  input  logic                                  clk,
  input  logic                                  i_avl_read,
  input  logic                                  i_avl_write,
  input  logic [line_cache_pkg::AVL_ADDR_W-1:0] i_avl_addr,
  input  logic [line_cache_pkg::LINE_W-1:0]     i_avl_wdata,
  output logic                                  o_avl_ready,
  output logic                                  o_avl_rdata_valid,
  output logic [line_cache_pkg::LINE_W-1:0]     o_avl_rdata,
  output int                                    o_read_count,
  output int                                    o_write_count
);

  import line_cache_pkg::*;

  localparam int LINES = 256;

  logic [LINE_W-1:0] mem [LINES];
  int                seed;
  int                stall;
  int                latency;
  logic              busy;
  logic              rd_pending;
  logic              acc_write;
  logic [7:0]        acc_index;
  logic [LINE_W-1:0] acc_data;

  // every word depends on its line index and its word position
  initial
  begin
    seed              = 32'hf0cd_3835;
    busy              = 1'b0;
    rd_pending        = 1'b0;
    stall             = 0;
    latency           = 0;
    o_avl_ready       = 1'b0;
    o_avl_rdata_valid = 1'b0;
    o_avl_rdata       = '0;
    o_read_count      = 0;
    o_write_count     = 0;
    for (int l = 0; l < LINES; l++)
    begin
      for (int w = 0; w < 4; w++)
      begin
        mem[l][w*32 +: 32] = {8'(l), 8'(~l), 8'(w * 37 + 3), 8'(l ^ (w << 4))};
      end
    end
  end

  always @(negedge clk)
  begin
    o_avl_rdata_valid <= 1'b0;
    if (o_avl_ready)
    begin
      // request was held through the last rising edge, so it was taken
      o_avl_ready <= 1'b0;
      if (acc_write)
      begin
        mem[acc_index] = acc_data;
        o_write_count <= o_write_count + 1;
      end
      else
      begin
        o_read_count <= o_read_count + 1;
        rd_pending = 1'b1;
        latency    = $unsigned($random(seed)) % 5;
      end
    end
    else if (rd_pending)
    begin
      if (latency == 0)
      begin
        o_avl_rdata_valid <= 1'b1;
        o_avl_rdata       <= mem[acc_index];
        rd_pending = 1'b0;
      end
      else
      begin
        latency = latency - 1;
      end
    end
    else if (i_avl_read || i_avl_write)
    begin
      if (!busy)
      begin
        // new command, pick its stall length
        busy  = 1'b1;
        stall = $unsigned($random(seed)) % 4;
      end
      if (stall == 0)
      begin
        o_avl_ready <= 1'b1;
        busy      = 1'b0;
        acc_write = i_avl_write;
        acc_index = i_avl_addr[11:4];
        acc_data  = i_avl_wdata;
      end
      else
      begin
        stall = stall - 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/ddr3_line_cache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr3_line_cache_tb;

  import line_cache_pkg::*;

  localparam int ACK_TIMEOUT  = 200;
  localparam int RESET_CYCLES = 16;
  localparam int HIT_LATENCY  = 2;
  localparam int RANDOM_OPS   = 200;

  logic                  clk;
  logic                  rst;
  logic                  membus_req;
  logic                  membus_write;
  logic [31:0]           membus_addr;
  logic [31:0]           membus_wdata;
  logic [3:0]            membus_wr_mask;
  logic                  membus_ack;
  logic [31:0]           membus_rdata;
  logic                  avl_ready;
  logic                  avl_rdata_valid;
  logic [LINE_W-1:0]     avl_rdata;
  logic                  avl_read;
  logic                  avl_write;
  logic [AVL_ADDR_W-1:0] avl_addr;
  logic [LINE_W-1:0]     avl_wdata;
  int                    read_count;
  int                    write_count;
  int                    error_count;
  int                    fail_count;
  int                    seed;
  bit                    stuck;
  logic [LINE_W-1:0]     shadow [256];

  tb_clock i_clock (
    .o_clk ( clk )
  );

  ddr3_line_cache i_dut (
    .clk               ( clk ),
    .rst               ( rst ),
    .i_membus_req      ( membus_req ),
    .i_membus_write    ( membus_write ),
    .i_membus_addr     ( membus_addr ),
    .i_membus_wdata    ( membus_wdata ),
    .i_membus_wr_mask  ( membus_wr_mask ),
    .i_avl_ready       ( avl_ready ),
    .i_avl_rdata_valid ( avl_rdata_valid ),
    .i_avl_rdata       ( avl_rdata ),
    .o_membus_ack      ( membus_ack ),
    .o_membus_rdata    ( membus_rdata ),
    .o_avl_read        ( avl_read ),
    .o_avl_write       ( avl_write ),
    .o_avl_addr        ( avl_addr ),
    .o_avl_wdata       ( avl_wdata )
  );

  avl_mem_model i_mem (
    .clk               ( clk ),
    .i_avl_read        ( avl_read ),
    .i_avl_write       ( avl_write ),
    .i_avl_addr        ( avl_addr ),
    .i_avl_wdata       ( avl_wdata ),
    .o_avl_ready       ( avl_ready ),
    .o_avl_rdata_valid ( avl_rdata_valid ),
    .o_avl_rdata       ( avl_rdata ),
    .o_read_count      ( read_count ),
    .o_write_count     ( write_count )
  );

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_cmd_count(input string name, input int exp, input int act);
    if (exp != act)
    begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  task automatic check_line(input string name, input logic [LINE_W-1:0] exp,
                            input logic [LINE_W-1:0] act);
    if (exp !== act)
    begin
      $display("Error %s: expected %h, actual %h", name, exp, act);
      error_count++;
    end
  endtask

  // line index in bits 11:4, word select in bits 3:2
  function automatic logic [31:0] make_addr(input logic [7:0] line, input logic [1:0] word);
    return {20'h0, line, word, 2'b00};
  endfunction

  function automatic logic [31:0] shadow_word(input logic [31:0] addr);
    return shadow[addr[11:4]][addr[3:2]*32 +: 32];
  endfunction

  task automatic merge_into_shadow(input logic [31:0] addr, input logic [31:0] wdata,
                                   input logic [3:0] mask);
    logic [7:0] idx;
    logic [1:0] word;
    idx  = addr[11:4];
    word = addr[3:2];
    for (int b = 0; b < 4; b++)
    begin
      if (mask[b])
      begin
        shadow[idx][word*32 + b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  endtask

  // one request, held until the ack; cycles counts falling edges up to the ack
  task automatic bus_access(input logic write, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] mask,
                            output logic [31:0] rdata, output int cycles, output bit done);
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    if (stuck)
    begin
      return;
    end
    @(negedge clk);
    membus_req     = 1'b1;
    membus_write   = write;
    membus_addr    = addr;
    membus_wdata   = wdata;
    membus_wr_mask = mask;
    while (!done && cycles < ACK_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
      done = membus_ack;
    end
    if (done)
    begin
      rdata = membus_rdata;
    end
    else
    begin
      $display("timeout: %s request to address %h was never acknowledged",
               write ? "write" : "read", addr);
      fail_count++;
      stuck = 1'b1;
    end
    membus_req     = 1'b0;
    membus_write   = 1'b0;
    membus_wdata   = '0;
    membus_wr_mask = '0;
  endtask

  task automatic read_and_check(input logic [31:0] addr);
    logic [31:0] rdata;
    int          cycles;
    bit          done;
    bus_access(1'b0, addr, '0, '0, rdata, cycles, done);
    if (done)
    begin
      check_word("o_membus_rdata", shadow_word(addr), rdata);
    end
  endtask

  task automatic write_and_check(input logic [31:0] addr, input logic [31:0] wdata,
                                 input logic [3:0] mask);
    logic [31:0] rdata;
    int          cycles;
    bit          done;
    merge_into_shadow(addr, wdata, mask);
    bus_access(1'b1, addr, wdata, mask, rdata, cycles, done);
    if (done)
    begin
      // write data is echoed on the read data bus
      check_word("o_membus_rdata", wdata, rdata);
    end
  endtask

  task automatic test_cold_read_miss();
    int reads0;
    int writes0;
    reads0  = read_count;
    writes0 = write_count;
    read_and_check(make_addr(8'h20, 2'd1));
    check_cmd_count("read_count", reads0 + 1, read_count);
    check_cmd_count("write_count", writes0, write_count);
  endtask

  task automatic test_read_hit_timing();
    logic [31:0] rdata;
    int          cycles;
    bit          done;
    int          reads0;
    int          writes0;
    reads0  = read_count;
    writes0 = write_count;
    for (int w = 0; w < 4; w++)
    begin
      bus_access(1'b0, make_addr(8'h20, 2'(w)), '0, '0, rdata, cycles, done);
      if (done)
      begin
        check_word("o_membus_rdata", shadow_word(make_addr(8'h20, 2'(w))), rdata);
        if (cycles - 1 != HIT_LATENCY)
        begin
          $display("read hit to word %0d acknowledged %0d cycles after the request, expected %0d",
                   w, cycles - 1, HIT_LATENCY);
          fail_count++;
        end
      end
    end
    check_cmd_count("read_count", reads0, read_count);
    check_cmd_count("write_count", writes0, write_count);
  endtask

  task automatic test_masked_writes();
    logic [3:0] masks [5];
    int         reads0;
    int         writes0;
    masks   = '{4'b0001, 4'b0110, 4'b1000, 4'b1111, 4'b0101};
    reads0  = read_count;
    writes0 = write_count;
    for (int i = 0; i < 5; i++)
    begin
      write_and_check(make_addr(8'h20, 2'd2), 32'hc0de_0000 + i * 32'h1111, masks[i]);
      read_and_check(make_addr(8'h20, 2'd2));
    end
    write_and_check(make_addr(8'h20, 2'd0), 32'h1234_5678, 4'b1001);
    read_and_check(make_addr(8'h20, 2'd0));
    check_cmd_count("read_count", reads0, read_count);
    check_cmd_count("write_count", writes0, write_count);
  endtask

  task automatic test_dirty_eviction();
    int reads0;
    int writes0;
    reads0  = read_count;
    writes0 = write_count;
    read_and_check(make_addr(8'h35, 2'd0));
    check_cmd_count("read_count", reads0 + 1, read_count);
    check_cmd_count("write_count", writes0 + 1, write_count);
    check_line("model line 20", shadow[8'h20], i_mem.mem[8'h20]);
    // back to the old line, the line at 35 was only read
    read_and_check(make_addr(8'h20, 2'd2));
    read_and_check(make_addr(8'h20, 2'd0));
    check_cmd_count("read_count", reads0 + 2, read_count);
    check_cmd_count("write_count", writes0 + 1, write_count);
  endtask

  task automatic test_clean_eviction();
    int reads0;
    int writes0;
    reads0  = read_count;
    writes0 = write_count;
    read_and_check(make_addr(8'h40, 2'd1));
    read_and_check(make_addr(8'h41, 2'd3));
    check_cmd_count("read_count", reads0 + 2, read_count);
    check_cmd_count("write_count", writes0, write_count);
  endtask

  task automatic test_random_traffic();
    logic [7:0]  line;
    logic [1:0]  word;
    logic [31:0] data;
    logic [3:0]  mask;
    for (int i = 0; i < RANDOM_OPS; i++)
    begin
      line = 8'h60 + 8'($unsigned($random(seed)) % 8);
      word = 2'($random(seed));
      if ($random(seed) & 1)
      begin
        data = $random(seed);
        mask = 4'($random(seed));
        write_and_check(make_addr(line, word), data, mask);
      end
      else
      begin
        read_and_check(make_addr(line, word));
      end
    end
    // move off the last line so every touched line sits in the model
    read_and_check(make_addr(8'h70, 2'd0));
    for (int l = 8'h60; l < 8'h68; l++)
    begin
      check_line($sformatf("model line %h", l), shadow[l], i_mem.mem[l]);
    end
  endtask

  initial
  begin
    seed           = 32'hf0cd_3835;
    error_count    = 0;
    fail_count     = 0;
    stuck          = 1'b0;
    rst            = 1'b1;
    membus_req     = 1'b0;
    membus_write   = 1'b0;
    membus_addr    = '0;
    membus_wdata   = '0;
    membus_wr_mask = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int l = 0; l < 256; l++)
    begin
      shadow[l] = i_mem.mem[l];
    end

    test_cold_read_miss();
    test_read_hit_timing();
    test_masked_writes();
    test_dirty_eviction();
    test_clean_eviction();
    test_random_traffic();

    $display("errors: %0d value mismatches, %0d other failures", error_count, fail_count);
    if (error_count == 0 && fail_count == 0)
    begin
      $display("TEST RESULT: PASS");
    end
    else
    begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
  output logic o_clk
);

  // 20 ns period
  localparam int HALF_PERIOD = 10;

  initial
  begin
    o_clk = 1'b0;
    forever
    begin
      #HALF_PERIOD o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire
